/* nn_layer_settings.svh */
`ifndef NN_LAYER_SETTINGS_SVH
`define NN_LAYER_SETTINGS_SVH

// Elements in one input vector.
`define NN_INPUTS 15

// Neurons in the layer, each with its own weight row.
`define NN_NEURONS 4

// Word width of inputs, weights and results.
`define NN_WIDTH 32

// Fraction bits of the Q15.16 fixed point format.
`define NN_FRAC 16

`endif

/* nn_types_pkg.sv */
`include "nn_layer_settings.svh"

package nn_types_pkg;

	// The accumulator is wide enough for fifteen shifted products.
	localparam int NN_ACC_W = 48;

	typedef logic signed [`NN_WIDTH-1:0] nn_word_t;

	typedef logic signed [NN_ACC_W-1:0] nn_acc_t;

	// One delivered result, tagged with the neuron that produced it.
	typedef struct packed {
		logic [1:0] idx;
		nn_word_t value;
	} nn_result_t;

	// Weights in Q15.16, one row per neuron, all with magnitude below 1.0.
	localparam nn_word_t NN_WEIGHTS [`NN_NEURONS][`NN_INPUTS] = '{
		'{ 15886,  35807,  18031, -12571,  -6779,
		   -2751, -13323,   5505,  -5965,  30535,
		  -32337,  20184, -15772,  25573,  -7757},
		'{ 22017, -41203,   9088,  30411,  -5120,
		   48712, -17654,   2049, -28733,  13370,
		   60021,  -9931,   4472, -52006,  18800},
		'{-30172,   7764,  43915,  -1206,  25108,
		  -14490,  37002, -61440,  11223,  -3391,
		   19975,  28640, -44812,   6606, -21001},
		'{ 51122, -12877, -26404,  15555,   3300,
		  -39017,   8192,  24680,  -7311,  46336,
		  -19283,  -2222,  33003, -58911,  10987}
	};

endpackage

/* nn_ctrl_pkg.sv */
`include "nn_layer_settings.svh"

package nn_ctrl_pkg;

	import nn_types_pkg::*;

	typedef enum logic [1:0] {OP_FIRST, OP_ACC, OP_LAST} nn_op_e;

	typedef enum logic [1:0] {F_IDLE, F_SEND, F_REL} feeder_state_e;

	typedef enum logic [1:0] {D_IDLE, D_REQ, D_REL} drain_state_e;

	// One broadcast element of the input vector.
	typedef struct packed {
		nn_op_e op;
		logic [3:0] idx;
		nn_word_t data;
	} nn_elem_t;

endpackage

/* layer_feeder.sv */
`timescale 1ns/100ps
`include "nn_layer_settings.svh"

module layer_feeder
	import nn_types_pkg::*;
	import nn_ctrl_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic in_req,
	input nn_word_t in_data,
	output logic in_ack,
	input logic drain_busy,
	output nn_elem_t elem,
	output logic elem_valid
);

	feeder_state_e state;
	logic [3:0] count;
	logic flush;
	logic hold;
	logic accept;
	nn_op_e op;

	// The last element of a vector is in the neurons but the drain has not
	// captured it yet; flush covers that gap until drain_busy rises.
	assign hold = (count == 4'd0) && (drain_busy || flush);
	assign accept = (state == F_IDLE) && in_req && !hold;

	assign in_ack = (state != F_IDLE);
	assign elem_valid = (state == F_SEND);

	always_comb
	begin
		if (count == 4'd0)
			op = OP_FIRST;
		else if (count == 4'(`NN_INPUTS - 1))
			op = OP_LAST;
		else
			op = OP_ACC;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= F_IDLE;
			count <= 4'd0;
			flush <= 1'b0;
		end
		else
		begin
			case (state)
				F_IDLE:
				begin
					if (accept)
					begin
						state <= F_SEND;
						count <= (op == OP_LAST) ? 4'd0 : count + 4'd1;
					end
				end
				F_SEND:
				begin
					// The source may already have dropped in_req here.
					state <= in_req ? F_REL : F_IDLE;
				end
				default:
				begin
					if (!in_req)
						state <= F_IDLE;
				end
			endcase

			if (accept && (op == OP_LAST))
				flush <= 1'b1;
			else if (drain_busy)
				flush <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			elem <= '{op: op, idx: count, data: in_data};
	end

endmodule

/* neuron.sv */
`timescale 1ns/100ps
`include "nn_layer_settings.svh"

module neuron
	import nn_types_pkg::*;
	import nn_ctrl_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic [1:0] neuron_id,
	input nn_elem_t elem,
	input logic elem_valid,
	output nn_word_t result,
	output logic done
);

	localparam nn_acc_t ACC_MAX = {{(NN_ACC_W - `NN_WIDTH + 1){1'b0}}, {(`NN_WIDTH - 1){1'b1}}};
	localparam nn_acc_t ACC_MIN = {{(NN_ACC_W - `NN_WIDTH + 1){1'b1}}, {(`NN_WIDTH - 1){1'b0}}};

	nn_word_t weight;
	logic signed [2*`NN_WIDTH-1:0] product;
	nn_acc_t term;
	nn_acc_t acc;
	nn_acc_t sum;
	nn_word_t sat;
	nn_word_t relu;

	assign weight = NN_WEIGHTS[neuron_id][elem.idx];
	assign product = elem.data * weight;

	// Dropping the low fraction bits rounds toward minus infinity.
	assign term = product[2*`NN_WIDTH-1:`NN_FRAC];

	assign sum = (elem.op == OP_FIRST) ? term : acc + term;

	always_comb
	begin
		if (sum > ACC_MAX)
			sat = ACC_MAX[`NN_WIDTH-1:0];
		else if (sum < ACC_MIN)
			sat = ACC_MIN[`NN_WIDTH-1:0];
		else
			sat = sum[`NN_WIDTH-1:0];
	end

	// Rectifier on the saturated word.
	assign relu = sat[`NN_WIDTH-1] ? '0 : sat;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			done <= 1'b0;
		else
			done <= elem_valid && (elem.op == OP_LAST);
	end

	always_ff @(posedge clk)
	begin
		if (elem_valid)
		begin
			acc <= sum;
			if (elem.op == OP_LAST)
				result <= relu;
		end
	end

endmodule

/* layer_drain.sv */
`timescale 1ns/100ps
`include "nn_layer_settings.svh"

module layer_drain
	import nn_types_pkg::*;
	import nn_ctrl_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input nn_word_t results [`NN_NEURONS],
	input logic done,
	output logic drain_busy,
	output logic out_req,
	input logic out_ack,
	output nn_result_t out_data
);

	drain_state_e state;
	logic [1:0] cur;
	nn_word_t vals [`NN_NEURONS];
	logic capture;

	assign capture = (state == D_IDLE) && done;

	assign drain_busy = (state != D_IDLE);
	assign out_req = (state == D_REQ);

	// Index and value only change when out_req rises again.
	assign out_data.idx = cur;
	assign out_data.value = vals[cur];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= D_IDLE;
			cur <= 2'd0;
		end
		else
		begin
			case (state)
				D_IDLE:
				begin
					if (capture)
					begin
						cur <= 2'd0;
						state <= D_REQ;
					end
				end
				D_REQ:
				begin
					if (out_ack)
						state <= D_REL;
				end
				default:
				begin
					// Wait for the sink to release out_ack before the next word.
					if (!out_ack)
					begin
						if (cur == 2'(`NN_NEURONS - 1))
							state <= D_IDLE;
						else
						begin
							cur <= cur + 2'd1;
							state <= D_REQ;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
			vals <= results;
	end

endmodule

/* nn_layer.sv */
`timescale 1ns/100ps
`include "nn_layer_settings.svh"

module nn_layer
	import nn_types_pkg::*;
	import nn_ctrl_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic in_req,
	input nn_word_t in_data,
	output logic in_ack,
	output logic out_req,
	input logic out_ack,
	output nn_result_t out_data
);

	nn_elem_t elem;
	logic elem_valid;
	logic drain_busy;
	nn_word_t results [`NN_NEURONS];
	logic [`NN_NEURONS-1:0] done;

	layer_feeder i_layer_feeder (
		.clk(clk),
		.arst_n(arst_n),
		.in_req(in_req),
		.in_data(in_data),
		.in_ack(in_ack),
		.drain_busy(drain_busy),
		.elem(elem),
		.elem_valid(elem_valid)
	);

	for (genvar g = 0; g < `NN_NEURONS; g++)
	begin : g_neuron
		neuron i_neuron (
			.clk(clk),
			.arst_n(arst_n),
			.neuron_id(2'(g)),
			.elem(elem),
			.elem_valid(elem_valid),
			.result(results[g]),
			.done(done[g])
		);
	end

	// All neurons finish together, so neuron 0 strobes the capture.
	layer_drain i_layer_drain (
		.clk(clk),
		.arst_n(arst_n),
		.results(results),
		.done(done[0]),
		.drain_busy(drain_busy),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_data(out_data)
	);

endmodule

/* nn_layer_chk.sv */
`timescale 1ns/100ps
`include "nn_layer_settings.svh"

module nn_layer_chk
	import nn_types_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic in_req,
	input logic in_ack,
	input logic out_req,
	input logic out_ack,
	input nn_result_t out_data
);

	int fail_count = 0;

	ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(in_ack) |-> in_req)
	else
	begin
		$error("in_ack rose while in_req was low");
		fail_count++;
	end

	req_holds: assert property (@(posedge clk) disable iff (!arst_n)
		out_req && !out_ack |=> out_req)
	else
	begin
		$error("out_req fell before out_ack");
		fail_count++;
	end

	data_stable: assert property (@(posedge clk) disable iff (!arst_n)
		out_req && $past(out_req) |-> $stable(out_data))
	else
	begin
		$error("out_data changed while out_req was high");
		fail_count++;
	end

	quiet_in_reset: assert property (@(posedge clk)
		!arst_n |-> !in_ack && !out_req)
	else
	begin
		$error("handshake output high during reset");
		fail_count++;
	end

endmodule

bind nn_layer nn_layer_chk i_nn_layer_chk (
	.clk(clk),
	.arst_n(arst_n),
	.in_req(in_req),
	.in_ack(in_ack),
	.out_req(out_req),
	.out_ack(out_ack),
	.out_data(out_data)
);

/* tb_nn_layer.sv */
`timescale 1ns/100ps
`include "nn_layer_settings.svh"

module tb_nn_layer
	import nn_types_pkg::*;
;

	localparam int NUM_VEC = 8;
	localparam int TOTAL = NUM_VEC * `NN_NEURONS;
	localparam int LIMIT = NUM_VEC * 400;

	logic clk;
	logic arst_n;
	logic in_req;
	nn_word_t in_data;
	logic in_ack;
	logic out_req;
	logic out_ack;
	nn_result_t out_data;

	nn_word_t in_vec [NUM_VEC][`NN_INPUTS];
	nn_result_t exp_res [NUM_VEC][`NN_NEURONS];
	int max_gap [NUM_VEC];
	int ack_extra [NUM_VEC];
	string vec_name [NUM_VEC];

	int errors;
	int checks;
	int req_rises;
	int cycles;
	logic req_prev;

	nn_layer i_nn_layer (
		.clk(clk),
		.arst_n(arst_n),
		.in_req(in_req),
		.in_data(in_data),
		.in_ack(in_ack),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_data(out_data)
	);

	always #5 clk = ~clk;

	// Reference neuron with truncated products, a wide sum, saturation and then the rectifier.
	function automatic nn_word_t model_neuron(input int n, input int v);
		longint sum;
		longint prod;
		nn_word_t sat;
		sum = 0;
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			prod = longint'(in_vec[v][i]) * longint'(NN_WEIGHTS[n][i]);
			sum = sum + (prod >>> `NN_FRAC);
		end
		if (sum > 64'sd2147483647)
			sat = 32'sh7fffffff;
		else if (sum < -64'sd2147483648)
			sat = 32'sh80000000;
		else
			sat = sum[`NN_WIDTH-1:0];
		return (sat < 0) ? '0 : sat;
	endfunction

	task automatic fill_table();
		for (int v = 0; v < NUM_VEC; v++)
		begin
			max_gap[v] = 3;
			ack_extra[v] = 0;
			vec_name[v] = "random";
			for (int i = 0; i < `NN_INPUTS; i++)
				in_vec[v][i] = $signed($urandom_range(32'h80000)) - 32'sh40000;
		end
		vec_name[0] = "all zero";
		vec_name[1] = "single element";
		vec_name[4] = "saturate high";
		vec_name[5] = "far below zero";
		vec_name[6] = "slow ack";
		vec_name[7] = "back to back";
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			in_vec[0][i] = '0;
			in_vec[1][i] = (i == 3) ? 32'sh00028000 : '0;
			// Signs follow neuron 0 so its sum runs far past either end.
			in_vec[4][i] = (NN_WEIGHTS[0][i] >= 0) ? 32'sh7fffffff : 32'sh80000000;
			in_vec[5][i] = (NN_WEIGHTS[0][i] >= 0) ? 32'sh80000000 : 32'sh7fffffff;
		end
		ack_extra[5] = 12;
		ack_extra[6] = 12;
		max_gap[6] = 0;
		max_gap[7] = 0;
		for (int v = 0; v < NUM_VEC; v++)
			for (int n = 0; n < `NN_NEURONS; n++)
				exp_res[v][n] = '{idx: 2'(n), value: model_neuron(n, v)};
	endtask

	task automatic check_result(input nn_result_t got, input nn_result_t exp);
		checks++;
		if (got !== exp)
		begin
			$display("[FAIL] %0t out_data got idx %0d value %h, expected idx %0d value %h",
				$time, got.idx, got.value, exp.idx, exp.value);
			errors++;
		end
	endtask

	task automatic check_count(input int got, input int exp);
		checks++;
		if (got != exp)
		begin
			$display("[FAIL] %0t result count got %0d, expected %0d", $time, got, exp);
			errors++;
		end
	endtask

	task automatic send_vectors();
		for (int v = 0; v < NUM_VEC; v++)
			for (int i = 0; i < `NN_INPUTS; i++)
			begin
				repeat ($urandom_range(max_gap[v])) @(posedge clk);
				#1;
				in_data = in_vec[v][i];
				in_req = 1'b1;
				do
					@(posedge clk);
				while (!in_ack);
				#1 in_req = 1'b0;
				do
					@(posedge clk);
				while (in_ack);
			end
	endtask

	task automatic receive_results();
		nn_result_t got;
		int v;
		int k;
		int err_start;
		err_start = 0;
		for (int n = 0; n < TOTAL; n++)
		begin
			v = n / `NN_NEURONS;
			k = n % `NN_NEURONS;
			if (k == 0)
				err_start = errors;
			do
				@(posedge clk);
			while (!out_req);
			got = out_data;
			repeat ($urandom_range(5) + ack_extra[v]) @(posedge clk);
			#1 out_ack = 1'b1;
			do
				@(posedge clk);
			while (out_req);
			repeat ($urandom_range(5)) @(posedge clk);
			#1 out_ack = 1'b0;
			check_result(got, exp_res[v][k]);
			if (k == `NN_NEURONS - 1)
				$display("vector %0d (%s): %0d mismatches", v, vec_name[v], errors - err_start);
		end
	endtask

	// Counts every delivery so that extra or missing results show up.
	always @(posedge clk)
	begin
		if (out_req && !req_prev)
			req_rises++;
		req_prev = out_req;
	end

	initial
	begin
		cycles = 0;
		while (cycles < LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Run stopped at the limit of %0d cycles before all vectors finished", LIMIT);
		$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		arst_n = 1'b0;
		in_req = 1'b0;
		in_data = '0;
		out_ack = 1'b0;
		req_prev = 1'b0;
		req_rises = 0;
		errors = 0;
		checks = 0;
		void'($urandom(32'hee067d7b));
		fill_table();
		if (exp_res[4][0].value != 32'sh7fffffff)
		begin
			$display("The large vector does not reach saturation in neuron 0");
			errors++;
		end
		repeat (10) @(posedge clk);
		#1 arst_n = 1'b1;
		@(posedge clk);
		fork
			send_vectors();
			receive_results();
		join
		repeat (40) @(posedge clk);
		check_count(req_rises, TOTAL);
		if (i_nn_layer.i_nn_layer_chk.fail_count != 0)
		begin
			$display("%0d protocol assertions failed during the run",
				i_nn_layer.i_nn_layer_chk.fail_count);
			errors = errors + i_nn_layer.i_nn_layer_chk.fail_count;
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* nn_layer.f */
+incdir+.
nn_types_pkg.sv
nn_ctrl_pkg.sv
layer_feeder.sv
neuron.sv
layer_drain.sv
nn_layer.sv
nn_layer_chk.sv
tb_nn_layer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the nn_layer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_nn_layer -f nn_layer.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

./obj_dir/Vtb_nn_layer +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi
